// ==== logic/p2r_pkg.sv ====
// constants and field widths for the power2round datapath, imported by the rtl and the checker
package p2r_pkg;

    // ============================================================
    // field arithmetic
    // ============================================================

    // modulus q, coefficients held in memory are always below it
    localparam logic [22:0] DILITHIUM_Q = 23'd8380417;
    localparam int COEF_W      = 23;
    localparam int DILITHIUM_D = 13;

    // rounding offset and t0 centre, both derived from d
    localparam int T1_ROUND  = (1 << (DILITHIUM_D - 1)) - 1;
    localparam int T0_OFFSET = 1 << (DILITHIUM_D - 1);

    // ============================================================
    // data widths
    // ============================================================

    localparam int REG_SIZE  = 24;
    localparam int LANES     = 4;
    localparam int T1_W      = 10;
    localparam int T0_W      = 13;
    localparam int CHUNK_W   = LANES * T0_W;
    localparam int SK_WORD_W = 32;
    localparam int PK_ADDR_W = 9;

    // ============================================================
    // stream geometry and flow control
    // ============================================================

    localparam int READS_PER_POLY    = 64;
    localparam int SK_WORDS_PER_POLY = 104;
    localparam int PIPE_DEPTH        = 3;
    localparam int BUF_W             = 256;

    // fill level up to which a new read may still be issued
    localparam int ROOM_LIMIT = BUF_W - PIPE_DEPTH * CHUNK_W;

endpackage

// ==== logic/p2r_reader.sv ====
// source read sequencer that walks all coefficient rows and pauses while the pack buffer is full
module p2r_reader #(
    parameter int NUM_POLY       = 8,
    parameter int MEM_ADDR_WIDTH = 15
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  logic                      enable,
    input  logic [MEM_ADDR_WIDTH-1:0] src_base_addr,
    input  logic                      buf_room,
    output logic                      mem_rd_en,
    output logic [MEM_ADDR_WIDTH-1:0] mem_rd_addr
);
    import p2r_pkg::*;

    localparam int TOTAL_READS = NUM_POLY * READS_PER_POLY;
    localparam int CNT_W       = $clog2(TOTAL_READS);

    logic             busy_q;
    logic [CNT_W-1:0] rd_cnt_q;
    logic             last_read;

    // a read goes out in every busy cycle with room left
    assign mem_rd_en   = busy_q & buf_room & ~zeroize;
    assign mem_rd_addr = src_base_addr + MEM_ADDR_WIDTH'(rd_cnt_q);
    assign last_read   = (rd_cnt_q == CNT_W'(TOTAL_READS - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q   <= 1'b0;
            rd_cnt_q <= '0;
        end else if (zeroize) begin
            busy_q   <= 1'b0;
            rd_cnt_q <= '0;
        end else if (enable) begin
            busy_q   <= 1'b1;
            rd_cnt_q <= '0;
        end else if (mem_rd_en) begin
            if (last_read) begin
                busy_q   <= 1'b0;
                rd_cnt_q <= '0;
            end else begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end
        end
    end

    // ============================================================
    // checks
    // ============================================================

    // a new start only arrives once the previous sweep has ended
    property p_start_when_idle;
        @(posedge clk) disable iff (!reset_n)
        enable |-> !busy_q;
    endproperty

    a_start_when_idle : assert property (p_start_when_idle);

endmodule

// ==== logic/p2r_decompose.sv ====
// two-stage power2round pipeline that splits four coefficients per cycle into t1 and encoded t0
module p2r_decompose (
    input  logic                                           clk,
    input  logic                                           reset_n,
    input  logic                                           zeroize,
    input  logic [p2r_pkg::LANES*p2r_pkg::REG_SIZE-1:0]    mem_rd_data,
    input  logic                                           mem_rd_valid,
    output logic                                           pk_t1_wren,
    output logic [p2r_pkg::PK_ADDR_W-1:0]                  pk_t1_wr_addr,
    output logic [p2r_pkg::LANES*p2r_pkg::T1_W-1:0]        pk_t1_wrdata,
    output logic                                           chunk_valid,
    output logic [p2r_pkg::CHUNK_W-1:0]                    chunk_data
);
    import p2r_pkg::*;

    logic [COEF_W-1:0]         coef_q [LANES];
    logic                      s1_valid_q;
    logic [COEF_W:0]           rounded [LANES];
    logic [T1_W-1:0]           t1_d [LANES];
    logic [T0_W-1:0]           t0_d [LANES];
    logic [LANES*T1_W-1:0]     t1_q;
    logic [CHUNK_W-1:0]        t0_q;
    logic                      s2_valid_q;
    logic [PK_ADDR_W-1:0]      wr_idx_q;

    // ============================================================
    // stage one captures the memory row
    // ============================================================

    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (zeroize) begin
                coef_q[i] <= '0;
            end else if (mem_rd_valid) begin
                coef_q[i] <= mem_rd_data[i*REG_SIZE +: COEF_W];
            end
        end
    end

    // ============================================================
    // decompose
    // ============================================================

    // t1 = (r + 4095) >> 13
    // r0 agrees with r in its low d bits modulo 8192
    // so the encoded t0 is simply 4096 - r[12:0] mod 8192
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            rounded[i] = {1'b0, coef_q[i]} + (COEF_W + 1)'(T1_ROUND);
            t1_d[i]    = rounded[i][DILITHIUM_D +: T1_W];
            t0_d[i]    = T0_W'(T0_OFFSET) - coef_q[i][T0_W-1:0];
        end
    end

    // stage two holds the results of one row
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (zeroize) begin
                t1_q[i*T1_W +: T1_W] <= '0;
                t0_q[i*T0_W +: T0_W] <= '0;
            end else if (s1_valid_q) begin
                t1_q[i*T1_W +: T1_W] <= t1_d[i];
                t0_q[i*T0_W +: T0_W] <= t0_d[i];
            end
        end
    end

    // valid pipe and pk write index
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
            wr_idx_q   <= '0;
        end else if (zeroize) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
            wr_idx_q   <= '0;
        end else begin
            s1_valid_q <= mem_rd_valid;
            s2_valid_q <= s1_valid_q;
            if (s2_valid_q) begin
                wr_idx_q <= wr_idx_q + 1'b1;
            end
        end
    end

    assign pk_t1_wren    = s2_valid_q;
    assign pk_t1_wr_addr = wr_idx_q;
    assign pk_t1_wrdata  = t1_q;
    assign chunk_valid   = s2_valid_q;
    assign chunk_data    = t0_q;

    // ============================================================
    // checks
    // ============================================================

    // memory contents come from an earlier reduction so every lane is below q
    for (genvar g = 0; g < LANES; g++) begin : g_lane_chk
        a_coef_below_q : assert property (
            @(posedge clk) disable iff (!reset_n)
            mem_rd_valid |-> (mem_rd_data[g*REG_SIZE +: REG_SIZE] < REG_SIZE'(DILITHIUM_Q))
        );
    end

endmodule

// ==== logic/p2r_pack_buffer.sv ====
// bit accumulator that repacks 52-bit t0 chunks into 32-bit secret-key words, lowest bits first
module p2r_pack_buffer (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize,
    input  logic                            chunk_valid,
    input  logic [p2r_pkg::CHUNK_W-1:0]     chunk_data,
    output logic                            buf_room,
    output logic                            word_valid,
    output logic [p2r_pkg::SK_WORD_W-1:0]   word_data
);
    import p2r_pkg::*;

    localparam int FILL_W = $clog2(BUF_W) + 1;

    logic [BUF_W-1:0]  buf_q;
    logic [BUF_W-1:0]  buf_shift;
    logic [BUF_W-1:0]  buf_next;
    logic [FILL_W-1:0] fill_q;
    logic [FILL_W-1:0] fill_shift;
    logic [FILL_W-1:0] fill_next;
    logic              drain;

    // a full word at the bottom leaves in this cycle
    assign drain      = (fill_q >= FILL_W'(SK_WORD_W));
    assign word_valid = drain;
    assign word_data  = buf_q[SK_WORD_W-1:0];

    // room for every chunk that a read in this cycle could still put in flight
    assign buf_room = (fill_q <= FILL_W'(ROOM_LIMIT));

    // ============================================================
    // next state
    // ============================================================

    always_comb begin
        if (drain) begin
            buf_shift  = buf_q >> SK_WORD_W;
            fill_shift = fill_q - FILL_W'(SK_WORD_W);
        end else begin
            buf_shift  = buf_q;
            fill_shift = fill_q;
        end

        buf_next  = buf_shift;
        fill_next = fill_shift;

        // new chunk lands right above the bits still held
        if (chunk_valid) begin
            buf_next  = buf_shift | ({{(BUF_W - CHUNK_W){1'b0}}, chunk_data} << fill_shift);
            fill_next = fill_shift + FILL_W'(CHUNK_W);
        end
    end

    // unused upper bits must stay zero for the or-merge above
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            buf_q  <= '0;
            fill_q <= '0;
        end else if (zeroize) begin
            buf_q  <= '0;
            fill_q <= '0;
        end else begin
            buf_q  <= buf_next;
            fill_q <= fill_next;
        end
    end

    // ============================================================
    // checks
    // ============================================================

    // holds only if the reader respects buf_room with the pipeline depth margin
    property p_fill_bounded;
        @(posedge clk) disable iff (!reset_n)
        fill_q <= FILL_W'(BUF_W);
    endproperty

    a_fill_bounded : assert property (p_fill_bounded);

endmodule

// ==== logic/p2r_sk_writer.sv ====
// secret-key memory writer, addresses each packed word and signals done after the last one
module p2r_sk_writer #(
    parameter int NUM_POLY      = 8,
    parameter int SK_ADDR_WIDTH = 14
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize,
    input  logic                            enable,
    input  logic [SK_ADDR_WIDTH-1:0]        sk_base_addr,
    input  logic                            word_valid,
    input  logic [p2r_pkg::SK_WORD_W-1:0]   word_data,
    output logic                            sk_wr_en,
    output logic [SK_ADDR_WIDTH-1:0]        sk_wr_addr,
    output logic [p2r_pkg::SK_WORD_W-1:0]   sk_wr_data,
    output logic                            done
);
    import p2r_pkg::*;

    localparam int TOTAL_WORDS = NUM_POLY * SK_WORDS_PER_POLY;
    localparam int CNT_W       = $clog2(TOTAL_WORDS);

    logic [SK_ADDR_WIDTH-1:0] base_q;
    logic [CNT_W-1:0]         cnt_q;
    logic                     last_word;
    logic                     last_q;

    assign last_word = word_valid & (cnt_q == CNT_W'(TOTAL_WORDS - 1));

    // write strobe, word count and done
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt_q    <= '0;
            sk_wr_en <= 1'b0;
            last_q   <= 1'b0;
            done     <= 1'b0;
        end else if (zeroize) begin
            cnt_q    <= '0;
            sk_wr_en <= 1'b0;
            last_q   <= 1'b0;
            done     <= 1'b0;
        end else begin
            sk_wr_en <= word_valid;
            last_q   <= last_word;
            done     <= last_q;
            if (enable || last_word) begin
                cnt_q <= '0;
            end else if (word_valid) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // base address and write payload
    always_ff @(posedge clk) begin
        if (zeroize) begin
            base_q     <= '0;
            sk_wr_addr <= '0;
            sk_wr_data <= '0;
        end else begin
            if (enable) begin
                base_q <= sk_base_addr;
            end
            if (word_valid) begin
                sk_wr_addr <= base_q + SK_ADDR_WIDTH'(cnt_q);
                sk_wr_data <= word_data;
            end
        end
    end

endmodule

// ==== logic/power2round_top.sv ====
// power2round subsystem top, wires the reader, decompose pipeline, pack buffer and sk writer
module power2round_top #(
    parameter int NUM_POLY       = 8,
    parameter int MEM_ADDR_WIDTH = 15,
    parameter int SK_ADDR_WIDTH  = 14
) (
    input  logic                                         clk,
    input  logic                                         reset_n,
    input  logic                                         zeroize,
    input  logic                                         enable,
    input  logic [MEM_ADDR_WIDTH-1:0]                    src_base_addr,
    input  logic [SK_ADDR_WIDTH-1:0]                     sk_base_addr,

    // source coefficient memory
    output logic                                         mem_rd_en,
    output logic [MEM_ADDR_WIDTH-1:0]                    mem_rd_addr,
    input  logic [p2r_pkg::LANES*p2r_pkg::REG_SIZE-1:0]  mem_rd_data,
    input  logic                                         mem_rd_valid,

    // public key t1
    output logic                                         pk_t1_wren,
    output logic [p2r_pkg::PK_ADDR_W-1:0]                pk_t1_wr_addr,
    output logic [p2r_pkg::LANES*p2r_pkg::T1_W-1:0]      pk_t1_wrdata,

    // secret key t0
    output logic                                         sk_wr_en,
    output logic [SK_ADDR_WIDTH-1:0]                     sk_wr_addr,
    output logic [p2r_pkg::SK_WORD_W-1:0]                sk_wr_data,

    output logic                                         done
);
    import p2r_pkg::*;

    logic                 buf_room;
    logic                 chunk_valid;
    logic [CHUNK_W-1:0]   chunk_data;
    logic                 word_valid;
    logic [SK_WORD_W-1:0] word_data;

    // ============================================================
    // producer side
    // ============================================================

    p2r_reader #(
        .NUM_POLY       (NUM_POLY),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) u_reader (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .enable        (enable),
        .src_base_addr (src_base_addr),
        .buf_room      (buf_room),
        .mem_rd_en     (mem_rd_en),
        .mem_rd_addr   (mem_rd_addr)
    );

    p2r_decompose u_decompose (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .mem_rd_data   (mem_rd_data),
        .mem_rd_valid  (mem_rd_valid),
        .pk_t1_wren    (pk_t1_wren),
        .pk_t1_wr_addr (pk_t1_wr_addr),
        .pk_t1_wrdata  (pk_t1_wrdata),
        .chunk_valid   (chunk_valid),
        .chunk_data    (chunk_data)
    );

    // ============================================================
    // buffer and consumer
    // ============================================================

    p2r_pack_buffer u_pack_buffer (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .chunk_valid (chunk_valid),
        .chunk_data  (chunk_data),
        .buf_room    (buf_room),
        .word_valid  (word_valid),
        .word_data   (word_data)
    );

    p2r_sk_writer #(
        .NUM_POLY      (NUM_POLY),
        .SK_ADDR_WIDTH (SK_ADDR_WIDTH)
    ) u_sk_writer (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .enable       (enable),
        .sk_base_addr (sk_base_addr),
        .word_valid   (word_valid),
        .word_data    (word_data),
        .sk_wr_en     (sk_wr_en),
        .sk_wr_addr   (sk_wr_addr),
        .sk_wr_data   (sk_wr_data),
        .done         (done)
    );

endmodule

// ==== tests/p2r_checker.sv ====
// scoreboard for power2round_top, rebuilds expected pk and sk writes from the source coefficients
module p2r_checker #(
    parameter int NUM_POLY       = 8,
    parameter int MEM_ADDR_WIDTH = 15,
    parameter int SK_ADDR_WIDTH  = 14
) (
    input logic                                     clk,
    input logic                                     reset_n,
    input logic                                     zeroize,
    input logic                                     mem_rd_en,
    input logic [MEM_ADDR_WIDTH-1:0]                mem_rd_addr,
    input logic                                     pk_t1_wren,
    input logic [p2r_pkg::PK_ADDR_W-1:0]            pk_t1_wr_addr,
    input logic [p2r_pkg::LANES*p2r_pkg::T1_W-1:0]  pk_t1_wrdata,
    input logic                                     sk_wr_en,
    input logic [SK_ADDR_WIDTH-1:0]                 sk_wr_addr,
    input logic [p2r_pkg::SK_WORD_W-1:0]            sk_wr_data,
    input logic                                     done
);
    timeunit 1ns;
    timeprecision 100ps;
    import p2r_pkg::*;

    localparam int ROWS  = NUM_POLY * READS_PER_POLY;
    localparam int WORDS = NUM_POLY * SK_WORDS_PER_POLY;

    int                    coef [ROWS*LANES];
    logic [LANES*T1_W-1:0] exp_pk [ROWS];
    logic [SK_WORD_W-1:0]  exp_sk [WORDS];
    int                    dir_t1 [LANES];
    int                    dir_t0 [LANES];
    int                    n_dir = 0;
    logic [63:0]           first_words = '0;
    int                    src_base = 0;
    int                    sk_base = 0;
    int                    pk_count = 0;
    int                    sk_count = 0;
    int                    done_count = 0;
    int                    error_count = 0;
    bit                    aborted = 1'b0;
    logic                  prev_sk_wr_en = 1'b0;

    // ============================================================
    // reference arithmetic
    // ============================================================

    function automatic int t1_of(input int r);
        return (r + 4095) >>> 13;
    endfunction

    function automatic int t0_of(input int r);
        int r0;
        r0 = r - t1_of(r) * 8192;
        return (4096 - r0) & 8191;
    endfunction

    task automatic report_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        error_count++;
        $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
    endtask

    task automatic report_event(input string what);
        error_count++;
        $display("%0t: %s", $time, what);
    endtask

    task automatic load_coef(input int k, input int value);
        coef[k] = value;
    endtask

    task automatic clear_directed();
        n_dir = 0;
    endtask

    task automatic add_directed(input int t1, input int t0);
        dir_t1[n_dir] = t1;
        dir_t0[n_dir] = t0;
        n_dir++;
    endtask

    // expected pk rows and the little-endian t0 word stream
    task automatic start_case(input int src, input int sk);
        logic [63:0] acc;
        int          nbits;
        int          w;
        src_base   = src;
        sk_base    = sk;
        pk_count   = 0;
        sk_count   = 0;
        done_count = 0;
        aborted    = 1'b0;
        acc        = '0;
        nbits      = 0;
        w          = 0;
        for (int j = 0; j < ROWS; j++) begin
            for (int i = 0; i < LANES; i++) begin
                exp_pk[j][i*T1_W +: T1_W] = T1_W'(t1_of(coef[j*LANES+i]));
                acc = acc | (64'(t0_of(coef[j*LANES+i])) << nbits);
                nbits += T0_W;
                if (nbits >= SK_WORD_W) begin
                    exp_sk[w] = acc[SK_WORD_W-1:0];
                    acc       = acc >> SK_WORD_W;
                    nbits    -= SK_WORD_W;
                    w++;
                end
            end
        end
    endtask

    task automatic check_idle();
        if (mem_rd_en !== 1'b0) report_value("mem_rd_en", 0, mem_rd_en);
        if (pk_t1_wren !== 1'b0) report_value("pk_t1_wren", 0, pk_t1_wren);
        if (sk_wr_en !== 1'b0) report_value("sk_wr_en", 0, sk_wr_en);
        if (done !== 1'b0) report_value("done", 0, done);
    endtask

    task automatic finish_case();
        if (pk_count != ROWS) begin
            report_event($sformatf("%0d public-key writes instead of %0d", pk_count, ROWS));
        end
        if (sk_count != WORDS) begin
            report_event($sformatf("%0d secret-key writes instead of %0d", sk_count, WORDS));
        end
        if (done_count != 1) begin
            report_event($sformatf("done pulsed %0d times instead of once", done_count));
        end
        // directed lanes sit in the first 52 stream bits
        for (int i = 0; i < n_dir; i++) begin
            if (first_words[i*T0_W +: T0_W] !== T0_W'(dir_t0[i])) begin
                report_value($sformatf("sk_wr_data t0 lane %0d", i), dir_t0[i],
                             first_words[i*T0_W +: T0_W]);
            end
        end
    endtask

    // ============================================================
    // port monitor, mid-cycle sampling
    // ============================================================

    always @(negedge clk) begin
        if (reset_n) begin
            if (mem_rd_en && (int'(mem_rd_addr) < src_base ||
                              int'(mem_rd_addr) >= src_base + ROWS)) begin
                report_event($sformatf("source read at %0d outside rows %0d to %0d",
                                       mem_rd_addr, src_base, src_base + ROWS - 1));
            end
            if (pk_t1_wren) begin
                if (aborted) begin
                    report_event("public-key write after zeroize");
                end else if (pk_count >= ROWS) begin
                    report_event("public-key write beyond the expected count");
                end else begin
                    if (pk_t1_wr_addr !== PK_ADDR_W'(pk_count)) begin
                        report_value("pk_t1_wr_addr", pk_count, pk_t1_wr_addr);
                    end
                    if (pk_t1_wrdata !== exp_pk[pk_count]) begin
                        report_value("pk_t1_wrdata", exp_pk[pk_count], pk_t1_wrdata);
                    end
                    for (int i = 0; i < n_dir && pk_count == 0; i++) begin
                        if (pk_t1_wrdata[i*T1_W +: T1_W] !== T1_W'(dir_t1[i])) begin
                            report_value($sformatf("pk_t1_wrdata lane %0d", i), dir_t1[i],
                                         pk_t1_wrdata[i*T1_W +: T1_W]);
                        end
                    end
                end
                pk_count++;
            end
            if (sk_wr_en) begin
                if (aborted) begin
                    report_event("secret-key write after zeroize");
                end else if (sk_count >= WORDS) begin
                    report_event("secret-key write beyond the expected count");
                end else begin
                    if (sk_wr_addr !== SK_ADDR_WIDTH'(sk_base + sk_count)) begin
                        report_value("sk_wr_addr", SK_ADDR_WIDTH'(sk_base + sk_count),
                                     sk_wr_addr);
                    end
                    if (sk_wr_data !== exp_sk[sk_count]) begin
                        report_value("sk_wr_data", exp_sk[sk_count], sk_wr_data);
                    end
                    if (sk_count < 2) begin
                        first_words[sk_count*SK_WORD_W +: SK_WORD_W] = sk_wr_data;
                    end
                end
                sk_count++;
            end
            if (done) begin
                done_count++;
                if (aborted) begin
                    report_event("done pulsed after zeroize");
                end else if (!prev_sk_wr_en || sk_count != WORDS) begin
                    report_event("done did not follow the last secret-key write by one cycle");
                end
            end
            prev_sk_wr_en = sk_wr_en;
            if (zeroize) begin
                aborted = 1'b1;
            end
        end
    end

endmodule

// ==== tests/tb_power2round_top.sv ====
// testbench top for power2round_top, runs every line of the case file through the DUT and checker
module tb_power2round_top;
    timeunit 1ns;
    timeprecision 100ps;
    import p2r_pkg::*;

    localparam int NUM_POLY       = 8;
    localparam int MEM_ADDR_WIDTH = 15;
    localparam int SK_ADDR_WIDTH  = 14;
    localparam int ROWS           = NUM_POLY * READS_PER_POLY;
    localparam int CLK_PERIOD     = 40;
    localparam int MAX_CASES      = 16;
    localparam int FIELDS         = 18;

    logic                          clk;
    logic                          reset_n;
    logic                          zeroize;
    logic                          enable;
    logic [MEM_ADDR_WIDTH-1:0]     src_base_addr;
    logic [SK_ADDR_WIDTH-1:0]      sk_base_addr;
    logic                          mem_rd_en;
    logic [MEM_ADDR_WIDTH-1:0]     mem_rd_addr;
    logic [LANES*REG_SIZE-1:0]     mem_rd_data;
    logic                          mem_rd_valid;
    logic                          pk_t1_wren;
    logic [PK_ADDR_W-1:0]          pk_t1_wr_addr;
    logic [LANES*T1_W-1:0]         pk_t1_wrdata;
    logic                          sk_wr_en;
    logic [SK_ADDR_WIDTH-1:0]      sk_wr_addr;
    logic [SK_WORD_W-1:0]          sk_wr_data;
    logic                          done;

    logic [LANES*REG_SIZE-1:0] src_mem [1 << MEM_ADDR_WIDTH];
    int                        case_field [MAX_CASES][FIELDS];
    int                        n_cases = 0;
    bit                        cases_loaded = 1'b0;
    int                        setup_errors = 0;
    logic [31:0]               lfsr;

    power2round_top #(
        .NUM_POLY       (NUM_POLY),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
        .SK_ADDR_WIDTH  (SK_ADDR_WIDTH)
    ) u_power2round_top (.*);

    p2r_checker #(
        .NUM_POLY       (NUM_POLY),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
        .SK_ADDR_WIDTH  (SK_ADDR_WIDTH)
    ) u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ============================================================
    // source memory, answers each read one cycle later
    // ============================================================

    initial begin
        logic                      en_s;
        logic [MEM_ADDR_WIDTH-1:0] addr_s;
        mem_rd_valid = 1'b0;
        mem_rd_data  = '0;
        forever begin
            @(negedge clk);
            en_s   = mem_rd_en;
            addr_s = mem_rd_addr;
            @(posedge clk);
            #1;
            mem_rd_valid = en_s;
            mem_rd_data  = en_s ? src_mem[addr_s] : '0;
        end
    end

    task automatic fill_background();
        for (int a = 0; a < (1 << MEM_ADDR_WIDTH); a++) begin
            src_mem[a] = {LANES{9'd0, 15'(a)}};
        end
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // 23 fresh bits per try, drawn again until below q
    task automatic draw_coef(output int value);
        logic [22:0] v;
        do begin
            for (int b = 0; b < 23; b++) begin
                lfsr = lfsr_next(lfsr);
                v    = {v[21:0], lfsr[0]};
            end
        end while (v >= DILITHIUM_Q);
        value = int'(v);
    endtask

    task automatic load_cases();
        int    fd;
        int    n;
        int    f [FIELDS];
        string line;
        fd = $fopen("tests/p2r_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file tests/p2r_cases.txt");
            setup_errors++;
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
            if (n != FIELDS) begin
                $display("malformed case line with %0d fields", n);
                setup_errors++;
                continue;
            end
            for (int k = 0; k < FIELDS; k++) begin
                case_field[n_cases][k] = f[k];
            end
            n_cases++;
        end
        $fclose(fd);
        if (n_cases == 0) begin
            $display("the case file holds no cases");
            setup_errors++;
        end
    endtask

    task automatic start_run(input int src, input int sk);
        u_checker.start_case(src, sk);
        @(posedge clk);
        #1;
        src_base_addr = MEM_ADDR_WIDTH'(src);
        sk_base_addr  = SK_ADDR_WIDTH'(sk);
        enable        = 1'b1;
        @(posedge clk);
        #1;
        enable = 1'b0;
    endtask

    // ============================================================
    // one case from the file
    // ============================================================

    task automatic run_case(input int c);
        int value;
        int row;
        int errs_before;
        if (case_field[c][0] != NUM_POLY) begin
            $display("case %0d asks for %0d polynomials but the DUT is built for %0d",
                     c + 1, case_field[c][0], NUM_POLY);
            setup_errors++;
            return;
        end
        if (case_field[c][3] != 0) lfsr = case_field[c][3];
        errs_before = u_checker.error_count;
        u_checker.clear_directed();
        for (int k = 0; k < ROWS * LANES; k++) begin
            if (k < case_field[c][5]) value = case_field[c][6 + 3 * k];
            else draw_coef(value);
            row = case_field[c][1] + k / LANES;
            src_mem[row][(k % LANES) * REG_SIZE +: REG_SIZE] = REG_SIZE'(value);
            u_checker.load_coef(k, value);
        end
        for (int k = 0; k < case_field[c][5]; k++) begin
            u_checker.add_directed(case_field[c][7 + 3 * k], case_field[c][8 + 3 * k]);
        end
        // aborted run first, then a clean run on the same data
        if (case_field[c][4] > 0) begin
            start_run(case_field[c][1], case_field[c][2]);
            repeat (case_field[c][4]) @(posedge clk);
            #1;
            zeroize = 1'b1;
            @(posedge clk);
            #1;
            zeroize = 1'b0;
            repeat (20) @(posedge clk);
        end
        start_run(case_field[c][1], case_field[c][2]);
        do @(negedge clk); while (done !== 1'b1);
        repeat (4) @(negedge clk);
        u_checker.finish_case();
        $display("case %0d: %0d pk writes, %0d sk writes, %0d failed checks", c + 1,
                 u_checker.pk_count, u_checker.sk_count, u_checker.error_count - errs_before);
    endtask

    initial begin
        wait (cases_loaded);
        repeat (n_cases * 2 * 256 * NUM_POLY + 100) @(posedge clk);
        $display("timeout, the cases did not finish within the cycle budget");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int total_errors;
        reset_n       = 1'b0;
        zeroize       = 1'b0;
        enable        = 1'b0;
        src_base_addr = '0;
        sk_base_addr  = '0;
        lfsr          = 32'd95614;
        fill_background();
        load_cases();
        cases_loaded = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;
        @(negedge clk);
        u_checker.check_idle();
        for (int c = 0; c < n_cases; c++) begin
            run_case(c);
        end
        total_errors = u_checker.error_count + setup_errors;
        $display("%0d cases run, %0d failed checks", n_cases, total_errors);
        if (total_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
logic/p2r_pkg.sv
logic/p2r_reader.sv
logic/p2r_decompose.sv
logic/p2r_pack_buffer.sv
logic/p2r_sk_writer.sv
logic/power2round_top.sv
tests/p2r_checker.sv
tests/tb_power2round_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_power2round_top
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/p2r_cases.txt ====
# poly_count src_base sk_base lfsr_seed zeroize_at dir_count, then four groups of coef t1 t0
# zeroize_at counts cycles after enable (0 for none), lfsr_seed 0 keeps the running state
8 0 0 95614 0 4 0 0 4096 1 0 4095 4096 0 0 4097 1 8191
8 512 100 0 0 3 8191 1 4097 8192 1 4096 8380416 1023 4096 0 0 0
8 1024 2000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
8 3000 5000 0 300 0 0 0 0 0 0 0 0 0 0 0 0 0
8 32256 15000 0 0 4 8380416 1023 4096 4096 0 0 0 0 4096 4097 1 8191
8 7000 9000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
